// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data and address width
`define CPU_XLEN 32

// Architectural register count
`define CPU_REGS 32

// Width of a register number
`define CPU_REG_BITS 5

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: cpuPkg.sv
`include "cpu_defs.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        OpNop,
        OpAddu,
        OpSubu,
        OpAnd,
        OpOr,
        OpSlt,
        OpAddiu,
        OpOri,
        OpLui,
        OpLw,
        OpSw,
        OpBeq,
        OpBne,
        OpJ
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt,
        AluLui
    } aluOpT;

    typedef enum logic [1:0] {
        WbNone,
        WbAlu,
        WbMem
    } wbSourceT;

    // One decoded instruction
    typedef struct packed {
        opcodeT op;
        aluOpT aluOp;
        wbSourceT wbSource;
        logic [`CPU_REG_BITS-1:0] destReg;
        logic [`CPU_REG_BITS-1:0] srcReg1;
        logic [`CPU_REG_BITS-1:0] srcReg2;
        logic useSrc1;
        logic useSrc2;
        logic useImm;
        logic [`CPU_XLEN-1:0] imm;
        logic isBranch;
        logic isJump;
        logic memLoad;
        logic memStore;
    } ctrlWordT;

    // Value a later stage offers for forwarding
    typedef struct packed {
        logic valid;
        logic [`CPU_REG_BITS-1:0] regNum;
        logic [`CPU_XLEN-1:0] value;
    } fwdSourceT;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic regWrite;
        logic [`CPU_REG_BITS-1:0] regNum;
        logic [`CPU_XLEN-1:0] data;
    } commitT;

endpackage

// File: instructionDecoder.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instructionDecoder (
    input  logic [`CPU_XLEN-1:0] instr,
    output cpuPkg::ctrlWordT ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [`CPU_XLEN-1:0] signImm;
    logic [`CPU_XLEN-1:0] zeroImm;
    cpuPkg::opcodeT op;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign signImm = {{(`CPU_XLEN - 16){instr[15]}}, instr[15:0]};
    assign zeroImm = {{(`CPU_XLEN - 16){1'b0}}, instr[15:0]};

    always_comb begin
        op = cpuPkg::OpNop;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h21: op = cpuPkg::OpAddu;
                    6'h23: op = cpuPkg::OpSubu;
                    6'h24: op = cpuPkg::OpAnd;
                    6'h25: op = cpuPkg::OpOr;
                    6'h2a: op = cpuPkg::OpSlt;
                    default: op = cpuPkg::OpNop;
                endcase
            end
            6'h02: op = cpuPkg::OpJ;
            6'h04: op = cpuPkg::OpBeq;
            6'h05: op = cpuPkg::OpBne;
            6'h09: op = cpuPkg::OpAddiu;
            6'h0d: op = cpuPkg::OpOri;
            6'h0f: op = cpuPkg::OpLui;
            6'h23: op = cpuPkg::OpLw;
            6'h2b: op = cpuPkg::OpSw;
            default: op = cpuPkg::OpNop;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.op = op;
        ctrl.aluOp = cpuPkg::AluAdd;
        ctrl.wbSource = cpuPkg::WbNone;
        ctrl.srcReg1 = instr[25:21];
        ctrl.srcReg2 = instr[20:16];
        ctrl.imm = signImm;
        case (op)
            cpuPkg::OpAddu, cpuPkg::OpSubu, cpuPkg::OpAnd, cpuPkg::OpOr, cpuPkg::OpSlt: begin
                ctrl.useSrc1 = 1'b1;
                ctrl.useSrc2 = 1'b1;
                ctrl.destReg = instr[15:11];
                ctrl.wbSource = cpuPkg::WbAlu;
                case (op)
                    cpuPkg::OpSubu: ctrl.aluOp = cpuPkg::AluSub;
                    cpuPkg::OpAnd: ctrl.aluOp = cpuPkg::AluAnd;
                    cpuPkg::OpOr: ctrl.aluOp = cpuPkg::AluOr;
                    cpuPkg::OpSlt: ctrl.aluOp = cpuPkg::AluSlt;
                    default: ctrl.aluOp = cpuPkg::AluAdd;
                endcase
            end
            cpuPkg::OpAddiu, cpuPkg::OpOri: begin
                ctrl.useSrc1 = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.destReg = instr[20:16];
                ctrl.wbSource = cpuPkg::WbAlu;
                if (op == cpuPkg::OpOri) begin
                    ctrl.aluOp = cpuPkg::AluOr;
                    ctrl.imm = zeroImm;
                end
            end
            cpuPkg::OpLui: begin
                ctrl.useImm = 1'b1;
                ctrl.imm = zeroImm;
                ctrl.aluOp = cpuPkg::AluLui;
                ctrl.destReg = instr[20:16];
                ctrl.wbSource = cpuPkg::WbAlu;
            end
            cpuPkg::OpLw: begin
                ctrl.useSrc1 = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.memLoad = 1'b1;
                ctrl.destReg = instr[20:16];
                ctrl.wbSource = cpuPkg::WbMem;
            end
            cpuPkg::OpSw: begin
                // Address is base plus offset and rt holds the store data
                ctrl.useSrc1 = 1'b1;
                ctrl.useSrc2 = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.memStore = 1'b1;
            end
            cpuPkg::OpBeq, cpuPkg::OpBne: begin
                ctrl.useSrc1 = 1'b1;
                ctrl.useSrc2 = 1'b1;
                ctrl.isBranch = 1'b1;
            end
            cpuPkg::OpJ: begin
                ctrl.isJump = 1'b1;
                ctrl.imm = {{(`CPU_XLEN - 26){1'b0}}, instr[25:0]};
            end
            default: begin
                // Unknown encodings write nothing
                ctrl.op = cpuPkg::OpNop;
            end
        endcase
    end

endmodule

// File: registerFile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module registerFile (
    input  logic clk,
    input  logic reset,
    input  logic [`CPU_REG_BITS-1:0] readReg1,
    input  logic [`CPU_REG_BITS-1:0] readReg2,
    output logic [`CPU_XLEN-1:0] readData1,
    output logic [`CPU_XLEN-1:0] readData2,
    input  logic [`CPU_REG_BITS-1:0] writeReg,
    input  logic [`CPU_XLEN-1:0] writeData
);

    // Register 0 has no storage
    logic [`CPU_XLEN-1:0] regs [1:`CPU_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `CPU_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeReg != '0) begin
            regs[writeReg] <= writeData;
        end
    end

    assign readData1 = (readReg1 == '0) ? '0 : regs[readReg1];
    assign readData2 = (readReg2 == '0) ? '0 : regs[readReg2];

endmodule

// File: operandForward.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module operandForward #(
    parameter int NumSources = 3
) (
    input  logic [`CPU_REG_BITS-1:0] reqReg,
    input  logic [`CPU_XLEN-1:0] regValue,
    input  cpuPkg::fwdSourceT [NumSources-1:0] sources,
    output logic [`CPU_XLEN-1:0] value,
    output logic notReady
);

    logic matched;

    // Index 0 is the youngest stage and wins over older ones
    always_comb begin
        value = regValue;
        notReady = 1'b0;
        matched = 1'b0;
        for (int i = 0; i < NumSources; i++) begin
            if (!matched && sources[i].regNum != '0 && sources[i].regNum == reqReg) begin
                matched = 1'b1;
                value = sources[i].value;
                notReady = !sources[i].valid;
            end
        end
    end

endmodule

// File: integerAlu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module integerAlu (
    input  cpuPkg::aluOpT aluOp,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] result
);

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluOp)
            cpuPkg::AluAdd: begin
                result = a + b;
            end
            cpuPkg::AluSub: begin
                result = a - b;
            end
            cpuPkg::AluAnd: begin
                result = a & b;
            end
            cpuPkg::AluOr: begin
                result = a | b;
            end
            cpuPkg::AluSlt: begin
                result = {{(`CPU_XLEN - 1){1'b0}}, lessThan};
            end
            cpuPkg::AluLui: begin
                result = b << 16;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: cpuCore.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuCore (
    input  logic clk,
    input  logic reset,
    output logic [`CPU_XLEN-1:0] instAddr,
    input  logic [`CPU_XLEN-1:0] instData,
    output logic [`CPU_XLEN-1:0] memAddr,
    output logic memWrite,
    output logic [`CPU_XLEN-1:0] memWriteData,
    input  logic [`CPU_XLEN-1:0] memReadData,
    output logic commitValid,
    output cpuPkg::commitT commit
);

    typedef struct packed {
        logic bubble;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } decodeRegT;

    typedef struct packed {
        logic bubble;
        logic [`CPU_XLEN-1:0] pc;
        cpuPkg::ctrlWordT ctrl;
        logic [`CPU_XLEN-1:0] op1;
        logic [`CPU_XLEN-1:0] op2;
    } executeRegT;

    typedef struct packed {
        logic bubble;
        logic [`CPU_XLEN-1:0] pc;
        cpuPkg::ctrlWordT ctrl;
        logic [`CPU_XLEN-1:0] aluResult;
        logic [`CPU_XLEN-1:0] storeData;
    } memoryRegT;

    typedef struct packed {
        logic bubble;
        logic [`CPU_XLEN-1:0] pc;
        cpuPkg::ctrlWordT ctrl;
        logic [`CPU_XLEN-1:0] value;
    } writebackRegT;

    logic [`CPU_XLEN-1:0] pc;
    decodeRegT decReg;
    executeRegT exReg;
    memoryRegT memReg;
    writebackRegT wbReg;

    cpuPkg::fwdSourceT fwdE;
    cpuPkg::fwdSourceT fwdM;
    cpuPkg::fwdSourceT fwdW;

    cpuPkg::ctrlWordT decCtrl;
    logic [`CPU_XLEN-1:0] rfData1;
    logic [`CPU_XLEN-1:0] rfData2;
    logic [`CPU_XLEN-1:0] decOp1;
    logic [`CPU_XLEN-1:0] decOp2;
    logic decNotReady1;
    logic decNotReady2;
    logic stall;
    logic taken;
    logic redirect;
    logic [`CPU_XLEN-1:0] target;

    logic [`CPU_XLEN-1:0] exOp1;
    logic [`CPU_XLEN-1:0] exOp2;
    logic [`CPU_XLEN-1:0] aluB;
    logic [`CPU_XLEN-1:0] aluResult;
    logic [`CPU_XLEN-1:0] memResult;
    logic [`CPU_REG_BITS-1:0] wbWriteReg;

    // Fetch
    assign instAddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
            decReg.bubble <= 1'b1;
        end else if (!stall) begin
            pc <= redirect ? target : pc + `CPU_XLEN'd4;
            decReg.bubble <= 1'b0;
            decReg.pc <= pc;
            decReg.instr <= instData;
        end
    end

    // Decode stage with the register file beside it
    instructionDecoder decoder (
        .instr(decReg.instr),
        .ctrl(decCtrl)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .readReg1(decCtrl.srcReg1),
        .readReg2(decCtrl.srcReg2),
        .readData1(rfData1),
        .readData2(rfData2),
        .writeReg(wbWriteReg),
        .writeData(wbReg.value)
    );

    operandForward #(.NumSources(3)) decFwd1 (
        .reqReg(decCtrl.srcReg1),
        .regValue(rfData1),
        .sources({fwdW, fwdM, fwdE}),
        .value(decOp1),
        .notReady(decNotReady1)
    );

    operandForward #(.NumSources(3)) decFwd2 (
        .reqReg(decCtrl.srcReg2),
        .regValue(rfData2),
        .sources({fwdW, fwdM, fwdE}),
        .value(decOp2),
        .notReady(decNotReady2)
    );

    assign stall = !decReg.bubble
        && ((decCtrl.useSrc1 && decNotReady1) || (decCtrl.useSrc2 && decNotReady2));

    // Branch compare uses the forwarded operands
    always_comb begin
        taken = decCtrl.isJump;
        target = {decReg.pc[`CPU_XLEN-1:`CPU_XLEN-4], decCtrl.imm[25:0], 2'b00};
        if (decCtrl.isBranch) begin
            taken = (decCtrl.op == cpuPkg::OpBeq) ? (decOp1 == decOp2) : (decOp1 != decOp2);
            target = decReg.pc + `CPU_XLEN'd4 + {decCtrl.imm[`CPU_XLEN-3:0], 2'b00};
        end
    end

    assign redirect = !decReg.bubble && !stall && taken;

    // Execute
    always_ff @(posedge clk) begin
        if (reset) begin
            exReg.bubble <= 1'b1;
        end else begin
            exReg.bubble <= decReg.bubble || stall;
        end
        exReg.pc <= decReg.pc;
        exReg.ctrl <= decCtrl;
        exReg.op1 <= decOp1;
        exReg.op2 <= decOp2;
    end

    operandForward #(.NumSources(2)) exFwd1 (
        .reqReg(exReg.ctrl.srcReg1),
        .regValue(exReg.op1),
        .sources({fwdW, fwdM}),
        .value(exOp1),
        .notReady()
    );

    operandForward #(.NumSources(2)) exFwd2 (
        .reqReg(exReg.ctrl.srcReg2),
        .regValue(exReg.op2),
        .sources({fwdW, fwdM}),
        .value(exOp2),
        .notReady()
    );

    assign aluB = exReg.ctrl.useImm ? exReg.ctrl.imm : exOp2;

    integerAlu alu (
        .aluOp(exReg.ctrl.aluOp),
        .a(exOp1),
        .b(aluB),
        .result(aluResult)
    );

    // A load in execute names its destination but has no value yet
    assign fwdE.valid = exReg.ctrl.wbSource == cpuPkg::WbAlu;
    assign fwdE.regNum = exReg.bubble ? '0 : exReg.ctrl.destReg;
    assign fwdE.value = aluResult;

    // Memory
    always_ff @(posedge clk) begin
        if (reset) begin
            memReg.bubble <= 1'b1;
        end else begin
            memReg.bubble <= exReg.bubble;
        end
        memReg.pc <= exReg.pc;
        memReg.ctrl <= exReg.ctrl;
        memReg.aluResult <= aluResult;
        memReg.storeData <= exOp2;
    end

    assign memAddr = memReg.aluResult;
    assign memWriteData = memReg.storeData;
    assign memWrite = !memReg.bubble && memReg.ctrl.memStore;

    always_comb begin
        memResult = '0;
        if (memReg.ctrl.memLoad) begin
            memResult = memReadData;
        end else if (memReg.ctrl.wbSource == cpuPkg::WbAlu) begin
            memResult = memReg.aluResult;
        end
    end

    assign fwdM.valid = memReg.ctrl.wbSource != cpuPkg::WbNone;
    assign fwdM.regNum = memReg.bubble ? '0 : memReg.ctrl.destReg;
    assign fwdM.value = memResult;

    // Writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            wbReg.bubble <= 1'b1;
        end else begin
            wbReg.bubble <= memReg.bubble;
        end
        wbReg.pc <= memReg.pc;
        wbReg.ctrl <= memReg.ctrl;
        wbReg.value <= memResult;
    end

    assign wbWriteReg = wbReg.bubble ? '0 : wbReg.ctrl.destReg;

    assign fwdW.valid = 1'b1;
    assign fwdW.regNum = wbWriteReg;
    assign fwdW.value = wbReg.value;

    assign commitValid = !wbReg.bubble;
    assign commit.pc = wbReg.pc;
    assign commit.regWrite = wbWriteReg != '0;
    assign commit.regNum = wbWriteReg;
    assign commit.data = wbReg.value;

endmodule

// File: cpuTbTests.svh
`ifndef CPU_TB_TESTS_SVH
`define CPU_TB_TESTS_SVH

// Self loop with a NOP delay slot
task automatic endProgram();
    emit(encodeJ(26'(progLen)));
    emit(32'h0000_0000);
endtask

task automatic testAluImmediate();
    clearProgram();
    emit(encodeI(6'h0f, 5'd0, 5'd1, 16'h8001));
    emit(encodeI(6'h09, 5'd0, 5'd2, 16'hfff0));
    emit(encodeI(6'h0d, 5'd0, 5'd3, 16'h00ff));
    emit(encodeI(6'h09, 5'd0, 5'd4, 16'h0021));
    emit(32'h0000_0000);
    emit(encodeR(5'd1, 5'd2, 5'd5, 6'h21));
    emit(encodeR(5'd3, 5'd4, 5'd6, 6'h23));
    emit(encodeR(5'd2, 5'd3, 5'd7, 6'h24));
    emit(encodeR(5'd1, 5'd4, 5'd8, 6'h25));
    emit(encodeR(5'd1, 5'd4, 5'd9, 6'h2a));
    emit(encodeR(5'd4, 5'd1, 5'd10, 6'h2a));
    endProgram();
    runProgram(progLen + 2, 1'b1);
endtask

task automatic testForwarding();
    clearProgram();
    emit(encodeI(6'h09, 5'd0, 5'd1, 16'd5));
    emit(encodeR(5'd1, 5'd1, 5'd2, 6'h21));
    emit(encodeI(6'h09, 5'd0, 5'd3, 16'd7));
    emit(encodeR(5'd2, 5'd3, 5'd4, 6'h21));
    emit(encodeR(5'd2, 5'd4, 5'd5, 6'h23));
    emit(encodeI(6'h0d, 5'd4, 5'd6, 16'h0100));
    emit(encodeR(5'd5, 5'd1, 5'd7, 6'h25));
    emit(encodeR(5'd6, 5'd7, 5'd6, 6'h21));
    endProgram();
    runProgram(progLen + 2, 1'b1);
endtask

task automatic testLoadStore();
    clearProgram();
    emit(encodeI(6'h09, 5'd0, 5'd1, 16'h0040));
    emit(encodeI(6'h0f, 5'd0, 5'd2, 16'h1234));
    emit(encodeI(6'h0d, 5'd2, 5'd2, 16'h5678));
    emit(encodeI(6'h2b, 5'd1, 5'd2, 16'd0));
    emit(encodeI(6'h23, 5'd1, 5'd3, 16'd0));
    emit(encodeR(5'd3, 5'd2, 5'd4, 6'h21));
    emit(encodeI(6'h2b, 5'd1, 5'd4, 16'd4));
    emit(encodeI(6'h23, 5'd1, 5'd5, 16'd4));
    emit(encodeR(5'd5, 5'd0, 5'd6, 6'h21));
    emit(encodeI(6'h2b, 5'd1, 5'd6, 16'hfffc));
    endProgram();
    runProgram(progLen + 2, 1'b0);
endtask

task automatic testBranches();
    clearProgram();
    emit(encodeI(6'h09, 5'd0, 5'd1, 16'd1));
    emit(encodeI(6'h09, 5'd0, 5'd2, 16'd1));
    emit(encodeI(6'h04, 5'd1, 5'd2, 16'd2));
    emit(encodeI(6'h09, 5'd0, 5'd3, 16'd3));
    emit(encodeI(6'h09, 5'd0, 5'd4, 16'd99));
    emit(encodeI(6'h05, 5'd1, 5'd2, 16'd1));
    emit(encodeI(6'h09, 5'd0, 5'd6, 16'd6));
    emit(encodeI(6'h04, 5'd1, 5'd0, 16'd5));
    emit(encodeI(6'h09, 5'd0, 5'd7, 16'd7));
    emit(encodeI(6'h05, 5'd1, 5'd0, 16'd2));
    emit(encodeI(6'h09, 5'd0, 5'd8, 16'd8));
    emit(encodeI(6'h09, 5'd0, 5'd9, 16'd99));
    emit(encodeJ(26'd15));
    emit(encodeI(6'h09, 5'd0, 5'd10, 16'd10));
    emit(encodeI(6'h09, 5'd0, 5'd11, 16'd99));
    endProgram();
    runProgram(16, 1'b1);
endtask

task automatic testRegZeroRandom();
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [15:0] imm;
    clearProgram();
    emit(encodeI(6'h09, 5'd0, 5'd0, 16'd55));
    emit(encodeR(5'd0, 5'd0, 5'd1, 6'h21));
    emit(encodeI(6'h0d, 5'd0, 5'd0, 16'h00ff));
    emit(encodeR(5'd0, 5'd0, 5'd2, 6'h25));
    for (int i = 0; i < 40; i++) begin
        rs = 5'($urandom % 8);
        rt = 5'($urandom % 8);
        rd = 5'($urandom % 8);
        imm = 16'($urandom);
        case ($urandom % 8)
            0: emit(encodeR(rs, rt, rd, 6'h21));
            1: emit(encodeR(rs, rt, rd, 6'h23));
            2: emit(encodeR(rs, rt, rd, 6'h24));
            3: emit(encodeR(rs, rt, rd, 6'h25));
            4: emit(encodeR(rs, rt, rd, 6'h2a));
            5: emit(encodeI(6'h09, rs, rt, imm));
            6: emit(encodeI(6'h0d, rs, rt, imm));
            default: emit(encodeI(6'h0f, 5'd0, rt, imm));
        endcase
    end
    endProgram();
    runProgram(progLen + 2, 1'b1);
endtask

`endif

// File: cpuTb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb;

    localparam int NumTests = 5;
    localparam int ClockPeriod = 8;
    localparam int CyclesPerTest = 200;

    logic clk;
    logic reset;
    logic [`CPU_XLEN-1:0] instAddr;
    logic [`CPU_XLEN-1:0] instData;
    logic [`CPU_XLEN-1:0] memAddr;
    logic memWrite;
    logic [`CPU_XLEN-1:0] memWriteData;
    logic [`CPU_XLEN-1:0] memReadData;
    logic commitValid;
    cpuPkg::commitT commit;

    logic [`CPU_XLEN-1:0] instMem [0:255];
    logic [`CPU_XLEN-1:0] dataMem [0:255];
    logic [`CPU_XLEN-1:0] refMem [0:255];
    logic [`CPU_XLEN-1:0] refRegs [0:`CPU_REGS-1];
    cpuPkg::commitT expCommits [$];
    logic [`CPU_XLEN-1:0] expStoreAddr [$];
    logic [`CPU_XLEN-1:0] expStoreData [$];
    int progLen;
    int cycle;

    cpuCore uut (
        .clk(clk),
        .reset(reset),
        .instAddr(instAddr),
        .instData(instData),
        .memAddr(memAddr),
        .memWrite(memWrite),
        .memWriteData(memWriteData),
        .memReadData(memReadData),
        .commitValid(commitValid),
        .commit(commit)
    );

    // Both memories answer in the same cycle
    assign instData = instMem[instAddr[9:2]];
    assign memReadData = dataMem[memAddr[9:2]];

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (memWrite) begin
            dataMem[memAddr[9:2]] <= memWriteData;
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #(ClockPeriod / 2) clk = ~clk;
        end
    end

    task automatic stopWithFailure(input string reason);
        $display("%s at %0t", reason, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic string describeCommit(input cpuPkg::commitT c);
        return $sformatf("pc=%h wr=%b reg=%0d data=%h", c.pc, c.regWrite, c.regNum, c.data);
    endfunction

    task automatic checkCommit(input cpuPkg::commitT actual, input cpuPkg::commitT expected);
        if (actual !== expected) begin
            $display("Fail at %0t: commit got %s, expected %s",
                $time, describeCommit(actual), describeCommit(expected));
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkWord(input string name, input logic [`CPU_XLEN-1:0] addr,
                             input logic [`CPU_XLEN-1:0] actual,
                             input logic [`CPU_XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s at address %h got %h, expected %h",
                $time, name, addr, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s got %b, expected %b", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [25:0] index);
        return {6'h02, index};
    endfunction

    function automatic cpuPkg::opcodeT classify(input logic [31:0] w);
        case (w[31:26])
            6'h00: begin
                case (w[5:0])
                    6'h21: return cpuPkg::OpAddu;
                    6'h23: return cpuPkg::OpSubu;
                    6'h24: return cpuPkg::OpAnd;
                    6'h25: return cpuPkg::OpOr;
                    6'h2a: return cpuPkg::OpSlt;
                    default: return cpuPkg::OpNop;
                endcase
            end
            6'h02: return cpuPkg::OpJ;
            6'h04: return cpuPkg::OpBeq;
            6'h05: return cpuPkg::OpBne;
            6'h09: return cpuPkg::OpAddiu;
            6'h0d: return cpuPkg::OpOri;
            6'h0f: return cpuPkg::OpLui;
            6'h23: return cpuPkg::OpLw;
            6'h2b: return cpuPkg::OpSw;
            default: return cpuPkg::OpNop;
        endcase
    endfunction

    // Sequential model with one delay slot after every branch or jump
    task automatic referenceRun(input int count);
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] tgt;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] data;
        logic [31:0] addr;
        logic [4:0] dest;
        cpuPkg::commitT c;
        pc = `CPU_RESET_PC;
        npc = pc + 32'd4;
        expCommits.delete();
        expStoreAddr.delete();
        expStoreData.delete();
        for (int r = 0; r < `CPU_REGS; r++) begin
            refRegs[r] = '0;
        end
        for (int i = 0; i < count; i++) begin
            w = instMem[pc[9:2]];
            a = refRegs[w[25:21]];
            b = refRegs[w[20:16]];
            se = {{16{w[15]}}, w[15:0]};
            ze = {16'h0000, w[15:0]};
            dest = 5'd0;
            data = '0;
            tgt = npc + 32'd4;
            case (classify(w))
                cpuPkg::OpAddu: begin
                    dest = w[15:11];
                    data = a + b;
                end
                cpuPkg::OpSubu: begin
                    dest = w[15:11];
                    data = a - b;
                end
                cpuPkg::OpAnd: begin
                    dest = w[15:11];
                    data = a & b;
                end
                cpuPkg::OpOr: begin
                    dest = w[15:11];
                    data = a | b;
                end
                cpuPkg::OpSlt: begin
                    dest = w[15:11];
                    data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                end
                cpuPkg::OpAddiu: begin
                    dest = w[20:16];
                    data = a + se;
                end
                cpuPkg::OpOri: begin
                    dest = w[20:16];
                    data = a | ze;
                end
                cpuPkg::OpLui: begin
                    dest = w[20:16];
                    data = {w[15:0], 16'h0000};
                end
                cpuPkg::OpLw: begin
                    addr = a + se;
                    dest = w[20:16];
                    data = refMem[addr[9:2]];
                end
                cpuPkg::OpSw: begin
                    addr = a + se;
                    refMem[addr[9:2]] = b;
                    expStoreAddr.push_back(addr);
                    expStoreData.push_back(b);
                end
                cpuPkg::OpBeq: if (a == b) begin
                    tgt = pc + 32'd4 + {se[29:0], 2'b00};
                end
                cpuPkg::OpBne: if (a != b) begin
                    tgt = pc + 32'd4 + {se[29:0], 2'b00};
                end
                cpuPkg::OpJ: tgt = {pc[31:28], w[25:0], 2'b00};
                default: data = '0;
            endcase
            c.pc = pc;
            c.regWrite = dest != 5'd0;
            c.regNum = dest;
            c.data = data;
            expCommits.push_back(c);
            if (dest != 5'd0) begin
                refRegs[dest] = data;
            end
            pc = npc;
            npc = tgt;
        end
    endtask

    task automatic clearProgram();
        progLen = 0;
        for (int i = 0; i < 256; i++) begin
            instMem[i] = '0;
            dataMem[i] = '0;
            refMem[i] = '0;
        end
    endtask

    task automatic emit(input logic [31:0] w);
        instMem[progLen] = w;
        progLen++;
    endtask

    task automatic applyReset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        // Empty pipeline with fetch at the reset address
        checkWord("instAddr", instAddr, instAddr, `CPU_RESET_PC);
        checkFlag("commitValid", commitValid, 1'b0);
        checkFlag("memWrite", memWrite, 1'b0);
        reset = 1'b0;
    endtask

    task automatic runProgram(input int count, input bit backToBack);
        int idx;
        int last;
        int waited;
        referenceRun(count);
        applyReset();
        idx = 0;
        last = -1;
        waited = 0;
        while (idx < count) begin
            @(negedge clk);
            waited++;
            if (memWrite) begin
                if (expStoreAddr.size() == 0) begin
                    stopWithFailure("Store strobe with no store expected");
                end
                checkWord("memAddr", memAddr, memAddr, expStoreAddr.pop_front());
                checkWord("memWriteData", memAddr, memWriteData, expStoreData.pop_front());
            end
            if (commitValid) begin
                if (backToBack && last >= 0 && cycle != last + 1) begin
                    stopWithFailure("Commits were not on consecutive cycles");
                end
                checkCommit(commit, expCommits[idx]);
                idx++;
                last = cycle;
            end
            if (waited > CyclesPerTest) begin
                stopWithFailure("Program did not reach its commit count");
            end
        end
        if (expStoreAddr.size() != 0) begin
            stopWithFailure("An expected store never happened");
        end
        for (int i = 0; i < 256; i++) begin
            checkWord("dataMem", 32'(i * 4), dataMem[i], refMem[i]);
        end
        // Next program loads just after a rising edge
        @(posedge clk);
        #1;
    endtask

    `include "cpuTbTests.svh"

    initial begin
        #(CyclesPerTest * NumTests * ClockPeriod);
        $display("Watchdog expired, the simulation hung");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h72bf_dda3));
        reset = 1'b1;
        cycle = 0;
        clearProgram();
        testAluImmediate();
        testForwarding();
        testLoadStore();
        testBranches();
        testRegZeroRandom();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
cpuPkg.sv
instructionDecoder.sv
registerFile.sv
operandForward.sv
integerAlu.sv
cpuCore.sv
cpuTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= cpuTb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_TEXT  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
